// File: Bender.yml
package:
  name: branch_predictor

sources:
  - include_dirs:
      - .
    files:
      - bp_pkg.sv
      - micro_btb.sv
      - main_btb.sv
      - return_stack.sv
      - stage2_resolve.sv
      - branch_predictor.sv
      - target: test
        files:
          - bp_assertions.sv
          - bp_tb.sv

// File: bp_assertions.sv
`timescale 1ns/1ns
`include "bp_defs.svh"

module bp_assertions (
    input logic                    clk,
    input logic                    reset_i,
    input logic                    stall_i,
    input logic                    squash_i,
    input logic [`VADDR_WIDTH-1:0] squash_pc_i,
    input logic                    pred_valid_i,
    input logic [`VADDR_WIDTH-1:0] pred_pc_i,
    input logic                    redirect_i
);
    int fail_count = 0;

    // a redirect always carries a prediction
    assert property (@(posedge clk) disable iff (reset_i) redirect_i |-> pred_valid_i)
        else begin
            $error("redirect_o high without pred_valid_o");
            fail_count++;
        end

    // squash kills the prediction of its own cycle
    assert property (@(posedge clk) disable iff (reset_i) squash_i |-> !pred_valid_i)
        else begin
            $error("pred_valid_o high in a squash cycle");
            fail_count++;
        end

    // only an override gets through a stall
    assert property (@(posedge clk) disable iff (reset_i)
                     (stall_i && !redirect_i) |-> !pred_valid_i)
        else begin
            $error("pred_valid_o high under stall without redirect");
            fail_count++;
        end

    // first prediction after a squash fetches from the squash pc
    assert property (@(posedge clk) disable iff (reset_i)
                     squash_i |=> (!pred_valid_i || pred_pc_i == $past(squash_pc_i)))
        else begin
            $error("prediction after squash not at the squash pc");
            fail_count++;
        end

endmodule

bind branch_predictor bp_assertions u_bp_assertions (
    .clk          (clk),
    .reset_i      (reset_i),
    .stall_i      (stall_i),
    .squash_i     (squash_i),
    .squash_pc_i  (squash_pc_i),
    .pred_valid_i (pred_valid_o),
    .pred_pc_i    (pred_pc_o),
    .redirect_i   (redirect_o)
);

// File: bp_defs.svh
`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

// address and fetch block geometry
`define VADDR_WIDTH 32
`define RESET_PC 32'h8000_0000
`define BLOCK_BYTES 16
`define SLOT_WIDTH 2

// table sizes
`define UBTB_ENTRIES 16
`define BTB_SETS 64
`define BTB_TAG_WIDTH 10

// return stack
`define RAS_DEPTH 8

`endif

// File: bp_pkg.sv
package bp_pkg;

    // kind of the branch that ends a fetch block
    typedef enum logic [1:0] {
        BR_COND = 2'd0,
        BR_JUMP = 2'd1,
        BR_CALL = 2'd2,
        BR_RET  = 2'd3
    } br_kind_e;

endpackage

// File: bp_tb.sv
`timescale 1ns/1ns
`include "bp_defs.svh"

module bp_tb;
    localparam int TIMEOUT_CYCLES = 3000;
    localparam int RANDOM_CYCLES  = 2000;

    logic                      clk;
    logic                      reset_i;
    logic                      stall_i;
    logic                      squash_i;
    logic [`VADDR_WIDTH-1:0]   squash_pc_i;
    logic                      update_i;
    logic [`VADDR_WIDTH-1:0]   update_pc_i;
    bp_pkg::br_kind_e          update_kind_i;
    logic [`SLOT_WIDTH-1:0]    update_slot_i;
    logic [`VADDR_WIDTH-1:0]   update_target_i;
    logic                      update_taken_i;
    logic                      pred_valid_o;
    logic [`VADDR_WIDTH-1:0]   pred_pc_o;
    logic [`VADDR_WIDTH-1:0]   pred_target_o;
    logic                      pred_taken_o;
    logic                      redirect_o;

    int seed;
    int n_checks;
    int n_errors;
    int cycle_count;
    int seen_redirect;
    logic [`VADDR_WIDTH-1:0] last_redir_tgt;

    // reference state
    logic [`VADDR_WIDTH-1:0]   m_pc;
    logic                      m_s2_valid;
    logic [`VADDR_WIDTH-1:0]   m_s2_pc;
    logic [`VADDR_WIDTH-1:0]   m_s2_s1_tgt;
    logic                      rd_hit;
    bp_pkg::br_kind_e          rd_kind;
    logic [`SLOT_WIDTH-1:0]    rd_slot;
    logic [`VADDR_WIDTH-1:0]   rd_tgt;
    logic [1:0]                rd_ctr;
    logic                      b_valid [`BTB_SETS];
    logic [`BTB_TAG_WIDTH-1:0] b_tag [`BTB_SETS];
    bp_pkg::br_kind_e          b_kind [`BTB_SETS];
    logic [`SLOT_WIDTH-1:0]    b_slot [`BTB_SETS];
    logic [`VADDR_WIDTH-1:0]   b_tgt [`BTB_SETS];
    logic [1:0]                b_ctr [`BTB_SETS];
    logic                      u_valid [`UBTB_ENTRIES];
    logic [`BTB_TAG_WIDTH-1:0] u_tag [`UBTB_ENTRIES];
    logic [`VADDR_WIDTH-1:0]   u_tgt [`UBTB_ENTRIES];
    logic [`VADDR_WIDTH-1:0]   ras [$];

    branch_predictor dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, actual, expected);
        end
    endtask

    function automatic logic [31:0] rand_block();
        logic [31:0] r;
        r = $random(seed);
        // a few index bits plus one tag bit so entries alias
        return 32'h8000_0000 | (r & 32'h0000_13f0);
    endfunction

    task automatic model_step();
        logic [3:0]              ui;
        logic [5:0]              bi;
        logic                    u_hit;
        logic [`VADDR_WIDTH-1:0] s1_tgt;
        logic                    r_taken;
        logic [`VADDR_WIDTH-1:0] r_tgt;
        logic                    ovr;
        logic                    adv;
        ui = m_pc[7:4];
        u_hit = u_valid[ui] && (u_tag[ui] == m_pc[17:8]);
        s1_tgt = u_hit ? u_tgt[ui] : m_pc + `BLOCK_BYTES;
        r_taken = rd_hit && (rd_kind != bp_pkg::BR_COND || rd_ctr >= 2);
        if (!r_taken) begin
            r_tgt = m_s2_pc + `BLOCK_BYTES;
        end else if (rd_kind == bp_pkg::BR_RET && ras.size() != 0) begin
            r_tgt = ras[$];
        end else begin
            r_tgt = rd_tgt;
        end
        ovr = m_s2_valid && (r_tgt != m_s2_s1_tgt);
        adv = !squash_i && (ovr || !stall_i);
        check_value(pred_valid_o, adv, "pred_valid_o");
        check_value(redirect_o, adv && ovr, "redirect_o");
        if (adv) begin
            check_value(pred_pc_o, ovr ? m_s2_pc : m_pc, "pred_pc_o");
            check_value(pred_target_o, ovr ? r_tgt : s1_tgt, "pred_target_o");
            check_value(pred_taken_o, ovr ? r_taken : u_hit, "pred_taken_o");
        end
        // what the DUT redirected to, for the directed checks
        if (redirect_o === 1'b1) begin
            seen_redirect++;
            last_redir_tgt = pred_target_o;
        end
        // stack moves when a taken block leaves stage 2
        if (m_s2_valid && adv && r_taken) begin
            if (rd_kind == bp_pkg::BR_CALL) begin
                ras.push_back(m_s2_pc + 4 * rd_slot + 4);
                if (ras.size() > `RAS_DEPTH) begin
                    void'(ras.pop_front());
                end
            end else if (rd_kind == bp_pkg::BR_RET && ras.size() != 0) begin
                void'(ras.pop_back());
            end
        end
        if (squash_i) m_s2_valid = 1'b0;
        else if (adv) m_s2_valid = 1'b1;
        if (adv) begin
            m_s2_pc = m_pc;
            m_s2_s1_tgt = s1_tgt;
        end
        if (squash_i) m_pc = squash_pc_i;
        else if (ovr) m_pc = r_tgt;
        else if (!stall_i) m_pc = s1_tgt;
        // main btb entry of the next stage 2 block as it was before the update
        bi = m_s2_pc[9:4];
        rd_hit = b_valid[bi] && (b_tag[bi] == m_s2_pc[19:10]);
        rd_kind = b_kind[bi];
        rd_slot = b_slot[bi];
        rd_tgt = b_tgt[bi];
        rd_ctr = b_ctr[bi];
        if (update_i) begin
            bi = update_pc_i[9:4];
            if (!(b_valid[bi] && b_tag[bi] == update_pc_i[19:10])) begin
                b_ctr[bi] = update_taken_i ? 2'd2 : 2'd1;
            end else if (update_taken_i && b_ctr[bi] != 2'd3) begin
                b_ctr[bi] = b_ctr[bi] + 2'd1;
            end else if (!update_taken_i && b_ctr[bi] != 2'd0) begin
                b_ctr[bi] = b_ctr[bi] - 2'd1;
            end
            b_valid[bi] = 1'b1;
            b_tag[bi] = update_pc_i[19:10];
            b_kind[bi] = update_kind_i;
            b_slot[bi] = update_slot_i;
            b_tgt[bi] = update_target_i;
            ui = update_pc_i[7:4];
            if (update_taken_i) begin
                u_valid[ui] = 1'b1;
                u_tag[ui] = update_pc_i[17:8];
                u_tgt[ui] = update_target_i;
            end else if (u_valid[ui] && u_tag[ui] == update_pc_i[17:8]) begin
                u_valid[ui] = 1'b0;
            end
        end
    endtask

    task automatic drive_cycle(input logic stall, input logic squash, input logic [31:0] sq_pc,
                               input logic upd, input logic [31:0] u_pc,
                               input bp_pkg::br_kind_e kind, input logic [1:0] slot,
                               input logic [31:0] tgt, input logic taken);
        @(posedge clk);
        reset_i         <= 1'b0;
        stall_i         <= stall;
        squash_i        <= squash;
        squash_pc_i     <= sq_pc;
        update_i        <= upd;
        update_pc_i     <= u_pc;
        update_kind_i   <= kind;
        update_slot_i   <= slot;
        update_target_i <= tgt;
        update_taken_i  <= taken;
        @(negedge clk);
        model_step();
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle(0, 0, 0, 0, 0, bp_pkg::BR_COND, 0, 0, 0);
    endtask

    task automatic squash_to(input logic [31:0] pc);
        drive_cycle(0, 1, pc, 0, 0, bp_pkg::BR_COND, 0, 0, 0);
    endtask

    task automatic train_block(input logic [31:0] pc, input bp_pkg::br_kind_e kind,
                               input logic [1:0] slot, input logic [31:0] tgt,
                               input logic taken);
        drive_cycle(0, 0, 0, 1, pc, kind, slot, tgt, taken);
    endtask

    initial begin
        logic [31:0] r;
        seed = 70;
        n_checks = 0;
        n_errors = 0;
        cycle_count = 0;
        seen_redirect = 0;
        reset_i = 1'b1;
        stall_i = 1'b0;
        squash_i = 1'b0;
        squash_pc_i = '0;
        update_i = 1'b0;
        update_pc_i = '0;
        update_kind_i = bp_pkg::BR_COND;
        update_slot_i = '0;
        update_target_i = '0;
        update_taken_i = 1'b0;
        m_pc = `RESET_PC;
        m_s2_valid = 1'b0;
        rd_hit = 1'b0;
        for (int i = 0; i < `BTB_SETS; i++) b_valid[i] = 1'b0;
        for (int i = 0; i < `UBTB_ENTRIES; i++) u_valid[i] = 1'b0;
        ras.delete();
        // eighth edge releases reset inside the first driven cycle
        repeat (7) @(posedge clk);

        idle_cycles(20);
        squash_to(32'h8000_0400);
        idle_cycles(8);
        // jump found only by the main btb and then by both
        train_block(32'h8000_0100, bp_pkg::BR_JUMP, 2'd1, 32'h8000_0800, 1'b1);
        train_block(32'h8000_0100, bp_pkg::BR_JUMP, 2'd1, 32'h8000_0800, 1'b0);
        seen_redirect = 0;
        squash_to(32'h8000_0100);
        idle_cycles(8);
        check_value(seen_redirect != 0, 1, "stage 2 override of jump");
        check_value(last_redir_tgt, 32'h8000_0800, "override target of jump");
        train_block(32'h8000_0100, bp_pkg::BR_JUMP, 2'd1, 32'h8000_0800, 1'b1);
        seen_redirect = 0;
        squash_to(32'h8000_0100);
        idle_cycles(8);
        check_value(seen_redirect, 0, "override of jump already taken in stage 1");
        // conditional block trained up then down
        train_block(32'h8000_0200, bp_pkg::BR_COND, 2'd3, 32'h8000_0a00, 1'b1);
        train_block(32'h8000_0200, bp_pkg::BR_COND, 2'd3, 32'h8000_0a00, 1'b1);
        squash_to(32'h8000_0200);
        idle_cycles(8);
        train_block(32'h8000_0200, bp_pkg::BR_COND, 2'd3, 32'h8000_0a00, 1'b0);
        train_block(32'h8000_0200, bp_pkg::BR_COND, 2'd3, 32'h8000_0a00, 1'b0);
        squash_to(32'h8000_0200);
        idle_cycles(8);
        // call in slot 2 whose return comes back to call pc + 12
        train_block(32'h8000_0300, bp_pkg::BR_CALL, 2'd2, 32'h8000_0500, 1'b1);
        train_block(32'h8000_0500, bp_pkg::BR_RET, 2'd0, 32'h8000_0000, 1'b1);
        squash_to(32'h8000_0300);
        idle_cycles(4);
        check_value(last_redir_tgt, 32'h8000_030c, "return target from stack");
        idle_cycles(8);

        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            r = $random(seed);
            drive_cycle(r[1:0] == 2'd0, r[6:2] == 5'd0, rand_block(), !r[8],
                        rand_block(), bp_pkg::br_kind_e'(r[10:9]), r[12:11],
                        rand_block(), r[13] | r[14]);
        end

        $display("checks %0d errors %0d assertion failures %0d", n_checks, n_errors,
                 dut.u_bp_assertions.fail_count);
        if (n_errors == 0 && dut.u_bp_assertions.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: branch_predictor.sv
`timescale 1ns/1ns
`include "bp_defs.svh"

module branch_predictor (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      stall_i,
    input  logic                      squash_i,
    input  logic [`VADDR_WIDTH-1:0]   squash_pc_i,
    input  logic                      update_i,
    input  logic [`VADDR_WIDTH-1:0]   update_pc_i,
    input  bp_pkg::br_kind_e          update_kind_i,
    input  logic [`SLOT_WIDTH-1:0]    update_slot_i,
    input  logic [`VADDR_WIDTH-1:0]   update_target_i,
    input  logic                      update_taken_i,
    output logic                      pred_valid_o,
    output logic [`VADDR_WIDTH-1:0]   pred_pc_o,
    output logic [`VADDR_WIDTH-1:0]   pred_target_o,
    output logic                      pred_taken_o,
    output logic                      redirect_o
);
    logic [`VADDR_WIDTH-1:0] s1_pc;
    logic [`VADDR_WIDTH-1:0] s1_target;
    logic [`VADDR_WIDTH-1:0] ubtb_target;
    logic                    ubtb_hit;
    logic                    s2_valid_q;
    logic [`VADDR_WIDTH-1:0] s2_pc_q;
    logic [`VADDR_WIDTH-1:0] s2_s1_target_q;
    logic [`VADDR_WIDTH-1:0] btb_lookup_pc;
    logic                    btb_hit;
    bp_pkg::br_kind_e        btb_kind;
    logic [`SLOT_WIDTH-1:0]  btb_slot;
    logic [`VADDR_WIDTH-1:0] btb_target;
    logic [1:0]              btb_counter;
    logic                    ras_push;
    logic                    ras_pop;
    logic                    ras_empty;
    logic [`VADDR_WIDTH-1:0] ras_push_addr;
    logic [`VADDR_WIDTH-1:0] ras_top;
    logic                    s2_taken;
    logic [`VADDR_WIDTH-1:0] s2_target;
    logic                    override;
    logic                    s2_redirect;
    logic                    advance;

    assign s1_target = ubtb_hit ? ubtb_target : s1_pc + `BLOCK_BYTES;

    // squash beats override, override beats stall
    assign s2_redirect = override && !squash_i;
    assign advance     = !squash_i && (override || !stall_i);

    // re-read the held block so btb data stays with stage 2
    assign btb_lookup_pc = (stall_i && !override) ? s2_pc_q : s1_pc;

    micro_btb u_micro_btb (
        .clk             (clk),
        .reset_i         (reset_i),
        .lookup_pc_i     (s1_pc),
        .hit_o           (ubtb_hit),
        .target_o        (ubtb_target),
        .update_i        (update_i),
        .update_pc_i     (update_pc_i),
        .update_target_i (update_target_i),
        .update_taken_i  (update_taken_i)
    );

    main_btb u_main_btb (
        .clk             (clk),
        .reset_i         (reset_i),
        .lookup_pc_i     (btb_lookup_pc),
        .hit_o           (btb_hit),
        .kind_o          (btb_kind),
        .slot_o          (btb_slot),
        .target_o        (btb_target),
        .counter_o       (btb_counter),
        .update_i        (update_i),
        .update_pc_i     (update_pc_i),
        .update_kind_i   (update_kind_i),
        .update_slot_i   (update_slot_i),
        .update_target_i (update_target_i),
        .update_taken_i  (update_taken_i)
    );

    return_stack u_return_stack (
        .clk         (clk),
        .reset_i     (reset_i),
        .push_i      (ras_push),
        .push_addr_i (ras_push_addr),
        .pop_i       (ras_pop),
        .empty_o     (ras_empty),
        .top_o       (ras_top)
    );

    stage2_resolve u_stage2_resolve (
        .valid_i     (s2_valid_q),
        .advance_i   (advance),
        .pc_i        (s2_pc_q),
        .s1_target_i (s2_s1_target_q),
        .hit_i       (btb_hit),
        .kind_i      (btb_kind),
        .slot_i      (btb_slot),
        .target_i    (btb_target),
        .counter_i   (btb_counter),
        .ras_empty_i (ras_empty),
        .ras_top_i   (ras_top),
        .taken_o     (s2_taken),
        .target_o    (s2_target),
        .override_o  (override),
        .push_o      (ras_push),
        .push_addr_o (ras_push_addr),
        .pop_o       (ras_pop)
    );

    always_ff @(posedge clk) begin
        if (reset_i) begin
            s1_pc      <= `RESET_PC;
            s2_valid_q <= 1'b0;
        end else if (squash_i) begin
            s1_pc      <= squash_pc_i;
            s2_valid_q <= 1'b0;
        end else if (override) begin
            s1_pc      <= s2_target;
            s2_valid_q <= 1'b1;
        end else if (!stall_i) begin
            s1_pc      <= s1_target;
            s2_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s2_pc_q        <= s1_pc;
            s2_s1_target_q <= s1_target;
        end
    end

    assign pred_valid_o  = advance;
    assign redirect_o    = s2_redirect;
    assign pred_pc_o     = s2_redirect ? s2_pc_q : s1_pc;
    assign pred_target_o = s2_redirect ? s2_target : s1_target;
    assign pred_taken_o  = s2_redirect ? s2_taken : ubtb_hit;

endmodule

// File: main_btb.sv
`timescale 1ns/1ns
`include "bp_defs.svh"

module main_btb (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic [`VADDR_WIDTH-1:0]   lookup_pc_i,
    output logic                      hit_o,
    output bp_pkg::br_kind_e          kind_o,
    output logic [`SLOT_WIDTH-1:0]    slot_o,
    output logic [`VADDR_WIDTH-1:0]   target_o,
    output logic [1:0]                counter_o,
    input  logic                      update_i,
    input  logic [`VADDR_WIDTH-1:0]   update_pc_i,
    input  bp_pkg::br_kind_e          update_kind_i,
    input  logic [`SLOT_WIDTH-1:0]    update_slot_i,
    input  logic [`VADDR_WIDTH-1:0]   update_target_i,
    input  logic                      update_taken_i
);
    localparam int OFF_W = $clog2(`BLOCK_BYTES);
    localparam int IDX_W = $clog2(`BTB_SETS);

    logic [`BTB_SETS-1:0]      valid_q;
    logic [`BTB_TAG_WIDTH-1:0] tag_q [`BTB_SETS];
    bp_pkg::br_kind_e          kind_q [`BTB_SETS];
    logic [`SLOT_WIDTH-1:0]    slot_q [`BTB_SETS];
    logic [`VADDR_WIDTH-1:0]   target_q [`BTB_SETS];
    logic [1:0]                ctr_q [`BTB_SETS];

    logic [IDX_W-1:0]          lk_idx;
    logic [IDX_W-1:0]          upd_idx;
    logic [`BTB_TAG_WIDTH-1:0] upd_tag;
    logic                      upd_hit;
    logic [1:0]                upd_ctr;

    // read stage registers
    logic                      rd_valid_q;
    logic [`BTB_TAG_WIDTH-1:0] rd_tag_q;
    logic [`BTB_TAG_WIDTH-1:0] lk_tag_q;

    assign lk_idx  = lookup_pc_i[OFF_W +: IDX_W];
    assign upd_idx = update_pc_i[OFF_W +: IDX_W];
    assign upd_tag = update_pc_i[OFF_W+IDX_W +: `BTB_TAG_WIDTH];
    assign upd_hit = valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);

    // allocate weakly, otherwise saturate toward the outcome
    always_comb begin
        if (!upd_hit) begin
            upd_ctr = update_taken_i ? 2'd2 : 2'd1;
        end else if (update_taken_i) begin
            upd_ctr = (ctr_q[upd_idx] == 2'd3) ? 2'd3 : ctr_q[upd_idx] + 2'd1;
        end else begin
            upd_ctr = (ctr_q[upd_idx] == 2'd0) ? 2'd0 : ctr_q[upd_idx] - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q    <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= valid_q[lk_idx];
            if (update_i) begin
                valid_q[upd_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_tag_q  <= tag_q[lk_idx];
        lk_tag_q  <= lookup_pc_i[OFF_W+IDX_W +: `BTB_TAG_WIDTH];
        kind_o    <= kind_q[lk_idx];
        slot_o    <= slot_q[lk_idx];
        target_o  <= target_q[lk_idx];
        counter_o <= ctr_q[lk_idx];
        if (update_i) begin
            tag_q[upd_idx]    <= upd_tag;
            kind_q[upd_idx]   <= update_kind_i;
            slot_q[upd_idx]   <= update_slot_i;
            target_q[upd_idx] <= update_target_i;
            ctr_q[upd_idx]    <= upd_ctr;
        end
    end

    assign hit_o = rd_valid_q && (rd_tag_q == lk_tag_q);

endmodule

// File: micro_btb.sv
`timescale 1ns/1ns
`include "bp_defs.svh"

module micro_btb (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic [`VADDR_WIDTH-1:0]   lookup_pc_i,
    output logic                      hit_o,
    output logic [`VADDR_WIDTH-1:0]   target_o,
    input  logic                      update_i,
    input  logic [`VADDR_WIDTH-1:0]   update_pc_i,
    input  logic [`VADDR_WIDTH-1:0]   update_target_i,
    input  logic                      update_taken_i
);
    localparam int OFF_W = $clog2(`BLOCK_BYTES);
    localparam int IDX_W = $clog2(`UBTB_ENTRIES);

    logic [`UBTB_ENTRIES-1:0]  valid_q;
    logic [`BTB_TAG_WIDTH-1:0] tag_q [`UBTB_ENTRIES];
    logic [`VADDR_WIDTH-1:0]   target_q [`UBTB_ENTRIES];
    logic [IDX_W-1:0]          lk_idx;
    logic [IDX_W-1:0]          upd_idx;
    logic [`BTB_TAG_WIDTH-1:0] lk_tag;
    logic [`BTB_TAG_WIDTH-1:0] upd_tag;
    logic                      upd_hit;

    // index sits right above the block offset, tag right above the index
    assign lk_idx  = lookup_pc_i[OFF_W +: IDX_W];
    assign lk_tag  = lookup_pc_i[OFF_W+IDX_W +: `BTB_TAG_WIDTH];
    assign upd_idx = update_pc_i[OFF_W +: IDX_W];
    assign upd_tag = update_pc_i[OFF_W+IDX_W +: `BTB_TAG_WIDTH];

    assign hit_o    = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);
    assign target_o = target_q[lk_idx];
    assign upd_hit  = valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (update_i) begin
            if (update_taken_i) begin
                valid_q[upd_idx] <= 1'b1;
            end else if (upd_hit) begin
                // not taken any more, drop the guess
                valid_q[upd_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (update_i && update_taken_i) begin
            tag_q[upd_idx]    <= upd_tag;
            target_q[upd_idx] <= update_target_i;
        end
    end

endmodule

// File: return_stack.sv
`timescale 1ns/1ns
`include "bp_defs.svh"

module return_stack (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      push_i,
    input  logic [`VADDR_WIDTH-1:0]   push_addr_i,
    input  logic                      pop_i,
    output logic                      empty_o,
    output logic [`VADDR_WIDTH-1:0]   top_o
);
    localparam int PTR_W = $clog2(`RAS_DEPTH);

    logic [`VADDR_WIDTH-1:0] entry_q [`RAS_DEPTH];
    logic [PTR_W-1:0]        ptr_q;
    logic [PTR_W:0]          count_q;
    logic                    do_pop;
    logic [PTR_W-1:0]        wr_idx;

    assign empty_o = (count_q == '0);
    assign top_o   = entry_q[ptr_q];
    // pop on an empty stack does nothing
    assign do_pop  = pop_i && !empty_o;
    // push with pop overwrites the top in place
    assign wr_idx  = do_pop ? ptr_q : ptr_q + 1'b1;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ptr_q   <= '0;
            count_q <= '0;
        end else if (push_i && !do_pop) begin
            // wraps over the oldest entry when full
            ptr_q <= ptr_q + 1'b1;
            if (count_q != `RAS_DEPTH) begin
                count_q <= count_q + 1'b1;
            end
        end else if (do_pop && !push_i) begin
            ptr_q   <= ptr_q - 1'b1;
            count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            entry_q[wr_idx] <= push_addr_i;
        end
    end

endmodule

// File: stage2_resolve.sv
`timescale 1ns/1ns
`include "bp_defs.svh"

module stage2_resolve (
    input  logic                      valid_i,
    input  logic                      advance_i,
    input  logic [`VADDR_WIDTH-1:0]   pc_i,
    input  logic [`VADDR_WIDTH-1:0]   s1_target_i,
    input  logic                      hit_i,
    input  bp_pkg::br_kind_e          kind_i,
    input  logic [`SLOT_WIDTH-1:0]    slot_i,
    input  logic [`VADDR_WIDTH-1:0]   target_i,
    input  logic [1:0]                counter_i,
    input  logic                      ras_empty_i,
    input  logic [`VADDR_WIDTH-1:0]   ras_top_i,
    output logic                      taken_o,
    output logic [`VADDR_WIDTH-1:0]   target_o,
    output logic                      override_o,
    output logic                      push_o,
    output logic [`VADDR_WIDTH-1:0]   push_addr_o,
    output logic                      pop_o
);
    logic                    is_cond;
    logic                    is_call;
    logic                    is_ret;
    logic                    leaving;
    logic [`VADDR_WIDTH-1:0] fall_through;
    logic [`VADDR_WIDTH-1:0] slot_offset;

    assign is_cond = (kind_i == bp_pkg::BR_COND);
    assign is_call = (kind_i == bp_pkg::BR_CALL);
    assign is_ret  = (kind_i == bp_pkg::BR_RET);

    // unconditional kinds always taken, cond uses counter msb
    assign taken_o = hit_i && (!is_cond || counter_i[1]);

    assign fall_through = pc_i + `BLOCK_BYTES;

    always_comb begin
        if (!taken_o) begin
            target_o = fall_through;
        end else if (is_ret && !ras_empty_i) begin
            target_o = ras_top_i;
        end else begin
            target_o = target_i;
        end
    end

    assign override_o = valid_i && (target_o != s1_target_i);

    // return address is the instruction after the call slot
    assign slot_offset = {{(`VADDR_WIDTH-`SLOT_WIDTH-2){1'b0}}, slot_i, 2'b00};
    assign push_addr_o = pc_i + slot_offset + 32'd4;

    // stack moves only once, when the block leaves stage 2
    assign leaving = valid_i && advance_i && taken_o;
    assign push_o  = leaving && is_call;
    assign pop_o   = leaving && is_ret;

endmodule

// File: verilog.f
+incdir+.
bp_pkg.sv
micro_btb.sv
main_btb.sv
return_stack.sv
stage2_resolve.sv
branch_predictor.sv
bp_assertions.sv
bp_tb.sv
